// ==== dv/tb_checker.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module tb_checker (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`FPU_CMP_ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  input  logic                       awready_i,
  input  logic [31:0]                wdata_i,
  input  logic [3:0]                 wstrb_i,
  input  logic                       wvalid_i,
  input  logic                       wready_i,
  input  logic [1:0]                 bresp_i,
  input  logic                       bvalid_i,
  input  logic                       bready_i,
  input  logic [`FPU_CMP_ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  input  logic                       arready_i,
  input  logic [31:0]                rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  input  logic                       rready_i,
  output int unsigned                err_count_o,
  output int unsigned                check_count_o
);

  // Edges from the accepted start write until done is set.
  localparam int unsigned run_latency = 3;

  logic [31:0]                 a_m [`FPU_CMP_LANES];
  logic [31:0]                 b_m [`FPU_CMP_LANES];
  logic                        sig_m;
  logic [4*`FPU_CMP_LANES-1:0] run_exp;    // Run in flight.
  logic [4*`FPU_CMP_LANES-1:0] result_exp; // Last completed run.
  logic                        done_exp;
  logic                        sticky_exp;
  logic                        clear_pend;
  int unsigned                 run_cnt;
  int unsigned                 rd_off;
  logic [31:0]                 rd_exp;
  int unsigned                 errors = 0;
  int unsigned                 checks = 0;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // Maps binary32 onto an unsigned total order.
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic [3:0] model_flags(input logic [31:0] a, input logic [31:0] b,
                                             input logic sig);
    logic un;
    logic inv;
    logic lt;
    logic eq;
    un  = is_nan(a) || is_nan(b);
    inv = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]) || (sig && un);
    if (un) begin
      lt = 1'b0;
      eq = 1'b0;
    end else if (a[30:0] == 31'd0 && b[30:0] == 31'd0) begin
      lt = 1'b0;
      eq = 1'b1;
    end else begin
      eq = a == b;
      lt = order_key(a) < order_key(b);
    end
    return {lt, eq, un, inv};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] expected_word(input int unsigned off);
    logic [31:0] w;
    w = 32'd0;
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      if (off == `FPU_CMP_A_BASE + 4 * i) w = a_m[i];
      if (off == `FPU_CMP_B_BASE + 4 * i) w = b_m[i];
    end
    if (off == `FPU_CMP_CTRL) w = {30'd0, sig_m, 1'b0};
    if (off == `FPU_CMP_STATUS) w = {30'd0, sticky_exp, done_exp};
    if (off == `FPU_CMP_RESULT) w = 32'(result_exp);
    return w;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  // Advances the pipeline model by one clock edge.
  task automatic step_model();
    if (clear_pend) sticky_exp = 1'b0;
    clear_pend = 1'b0;
    if (run_cnt != 0) begin
      run_cnt--;
      if (run_cnt == run_latency - 1) done_exp = 1'b0; // Start pulse clears done.
      if (run_cnt == 0) begin
        done_exp   = 1'b1;
        result_exp = run_exp;
        for (int i = 0; i < `FPU_CMP_LANES; i++) begin
          sticky_exp = sticky_exp | run_exp[4*i];
        end
      end
    end
  endtask

  task automatic snoop_write(input int unsigned off, input logic [31:0] data,
                             input logic [3:0] strb);
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      if (off == `FPU_CMP_A_BASE + 4 * i) a_m[i] = merge_bytes(a_m[i], data, strb);
      if (off == `FPU_CMP_B_BASE + 4 * i) b_m[i] = merge_bytes(b_m[i], data, strb);
    end
    if (off == `FPU_CMP_CTRL && strb[0]) begin
      sig_m = data[1];
      if (data[0]) begin
        for (int i = 0; i < `FPU_CMP_LANES; i++) begin
          run_exp[4*i +: 4] = model_flags(a_m[i], b_m[i], sig_m); // Snapshot at start.
        end
        run_cnt = run_latency;
      end
    end
    if (off == `FPU_CMP_STATUS && strb[0] && data[1]) clear_pend = 1'b1;
  endtask

  task automatic check_read(input int unsigned off, input logic [31:0] expected,
                            input logic [31:0] data);
    if (off == `FPU_CMP_STATUS) begin
      compare("s_rdata_o STATUS", expected, data);
    end else if (off == `FPU_CMP_RESULT) begin
      compare("s_rdata_o RESULT", expected, data);
    end else begin
      compare($sformatf("s_rdata_o @0x%02h", off), expected, data);
    end
  endtask

  initial begin
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      a_m[i] = 32'd0;
      b_m[i] = 32'd0;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      sig_m      = 1'b0;
      run_exp    = '0;
      result_exp = '0;
      done_exp   = 1'b0;
      sticky_exp = 1'b0;
      clear_pend = 1'b0;
      run_cnt    = 0;
      rd_off     = 0;
      rd_exp     = 32'd0;
    end else begin
      if (bvalid_i && bready_i) compare("s_bresp_o", 32'd0, 32'(bresp_i));
      if (rvalid_i && rready_i) begin
        compare("s_rresp_o", 32'd0, 32'(rresp_i));
        check_read(rd_off, rd_exp, rdata_i);
      end
      if (rvalid_i) compare("s_arready_o", 32'd0, 32'(arready_i)); // One read in flight.
      if (arvalid_i && arready_i) begin
        rd_off = 32'({araddr_i[`FPU_CMP_ADDR_W-1:2], 2'b00});
        rd_exp = expected_word(rd_off); // Read data is taken at address accept.
      end
      step_model();
      if (awvalid_i && awready_i && wvalid_i && wready_i) begin
        snoop_write(32'({awaddr_i[`FPU_CMP_ADDR_W-1:2], 2'b00}), wdata_i, wstrb_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o; // Period 20.
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/tb_fpu_cmp.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module tb_fpu_cmp;

  typedef logic [`FPU_CMP_ADDR_W-1:0] addr_t;

  localparam int unsigned wait_limit  = 200;
  localparam int unsigned poll_limit  = 50;
  localparam int unsigned random_runs = 300;

  logic        clk;
  logic        rst_n;
  addr_t       awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  addr_t       araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] rng_state = 32'd55;
  logic [31:0] lane_a [`FPU_CMP_LANES];
  logic [31:0] lane_b [`FPU_CMP_LANES];
  int unsigned timeouts = 0;
  int unsigned err_count;
  int unsigned check_count;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fpu_cmp_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wstrb_i   (wstrb),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready)
  );

  tb_checker u_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .awaddr_i      (awaddr),
    .awvalid_i     (awvalid),
    .awready_i     (awready),
    .wdata_i       (wdata),
    .wstrb_i       (wstrb),
    .wvalid_i      (wvalid),
    .wready_i      (wready),
    .bresp_i       (bresp),
    .bvalid_i      (bvalid),
    .bready_i      (bready),
    .araddr_i      (araddr),
    .arvalid_i     (arvalid),
    .arready_i     (arready),
    .rdata_i       (rdata),
    .rresp_i       (rresp),
    .rvalid_i      (rvalid),
    .rready_i      (rready),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // About a third of the values are special encodings.
  function automatic logic [31:0] random_operand();
    logic [31:0] r;
    logic [31:0] v;
    if (rand32() % 3 != 0) return rand32();
    r = rand32();
    v = rand32();
    case (r[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7f80_0000;
      3'd3:    return 32'hff80_0000;
      3'd4:    return {v[31], 8'hff, 1'b1, v[21:0]};       // Quiet NaN.
      3'd5:    return {v[31], 8'hff, 1'b0, v[21:1], 1'b1}; // Signaling NaN.
      3'd6:    return {v[31], 8'h00, v[22:1], 1'b1};       // Subnormal.
      default: return {v[31], 8'h01, v[22:0]};
    endcase
  endfunction

  task automatic timed_out(input string what);
    $display("Timeout waiting for %s", what);
    timeouts++;
  endtask

  task automatic axi_write(input addr_t addr, input logic [31:0] data, input logic [3:0] strb);
    int unsigned cnt;
    logic        ok;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    ok  = 1'b0;
    cnt = 0;
    while (!ok && cnt < wait_limit) begin
      @(posedge clk);
      ok = awready && wready;
      cnt++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!ok) timed_out("write address and data accept");
    repeat (rand32() % 4) @(posedge clk); // Random back-pressure.
    bready <= 1'b1;
    ok  = 1'b0;
    cnt = 0;
    while (!ok && cnt < wait_limit) begin
      @(posedge clk);
      ok = bvalid;
      cnt++;
    end
    bready <= 1'b0;
    if (!ok) timed_out("write response");
  endtask

  task automatic axi_read(input addr_t addr, output logic [31:0] data);
    int unsigned cnt;
    logic        ok;
    data    = 32'd0;
    araddr  <= addr;
    arvalid <= 1'b1;
    ok  = 1'b0;
    cnt = 0;
    while (!ok && cnt < wait_limit) begin
      @(posedge clk);
      ok = arready;
      cnt++;
    end
    arvalid <= 1'b0;
    if (!ok) timed_out("read address accept");
    repeat (rand32() % 4) @(posedge clk);
    rready <= 1'b1;
    ok  = 1'b0;
    cnt = 0;
    while (!ok && cnt < wait_limit) begin
      @(posedge clk);
      ok = rvalid;
      cnt++;
    end
    rready <= 1'b0;
    if (ok) data = rdata;
    else timed_out("read data");
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int unsigned polls;
    logic        done_seen;
    done_seen = 1'b0;
    polls     = 0;
    while (!done_seen && polls < poll_limit) begin
      axi_read(addr_t'(`FPU_CMP_STATUS), status);
      done_seen = status[0] === 1'b1;
      polls++;
    end
    if (!done_seen) timed_out("done flag in STATUS");
  endtask

  task automatic set_pair(input int lane, input logic [31:0] a, input logic [31:0] b);
    lane_a[lane] = a;
    lane_b[lane] = b;
  endtask

  task automatic run_once(input logic sig, input logic late_writes);
    logic [31:0] res;
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      axi_write(addr_t'(`FPU_CMP_A_BASE + 4 * i), lane_a[i], 4'hf);
      axi_write(addr_t'(`FPU_CMP_B_BASE + 4 * i), lane_b[i], 4'hf);
    end
    axi_write(addr_t'(`FPU_CMP_CTRL), {30'd0, sig, 1'b1}, 4'hf);
    if (late_writes) begin
      for (int i = 0; i < `FPU_CMP_LANES; i++) begin
        axi_write(addr_t'(`FPU_CMP_A_BASE + 4 * i), random_operand(), 4'hf);
      end
    end
    wait_done();
    axi_read(addr_t'(`FPU_CMP_RESULT), res);
  endtask

  task automatic clear_sticky();
    logic [31:0] status;
    axi_read(addr_t'(`FPU_CMP_STATUS), status);
    axi_write(addr_t'(`FPU_CMP_STATUS), 32'h2, 4'h1);
    axi_read(addr_t'(`FPU_CMP_STATUS), status);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    int unsigned cnt;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = 32'd0;
    wstrb   = 4'h0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < wait_limit) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) timed_out("reset release");
    @(posedge clk);

    // Reset values and readback.
    axi_read(addr_t'(`FPU_CMP_STATUS), rd);
    axi_read(addr_t'(`FPU_CMP_RESULT), rd);
    axi_read(addr_t'(`FPU_CMP_CTRL), rd);
    axi_read(addr_t'('h3c), rd);
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      axi_write(addr_t'(`FPU_CMP_A_BASE + 4 * i), rand32(), 4'hf);
      axi_write(addr_t'(`FPU_CMP_B_BASE + 4 * i), rand32(), 4'hf);
    end
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      axi_read(addr_t'(`FPU_CMP_A_BASE + 4 * i), rd);
      axi_read(addr_t'(`FPU_CMP_B_BASE + 4 * i), rd);
    end
    axi_write(addr_t'(`FPU_CMP_A_BASE), 32'hdead_beef, 4'hf);
    axi_write(addr_t'(`FPU_CMP_A_BASE), 32'h1234_5678, 4'b0101);
    axi_read(addr_t'(`FPU_CMP_A_BASE), rd);

    // Zeros and infinities.
    set_pair(0, 32'h0000_0000, 32'h8000_0000);
    set_pair(1, 32'h8000_0000, 32'h0000_0000);
    set_pair(2, 32'h7f80_0000, 32'h7f80_0000);
    set_pair(3, 32'hff80_0000, 32'h7f80_0000);
    run_once(1'b0, 1'b0);
    // Subnormals and negative magnitudes.
    set_pair(0, 32'h0000_0001, 32'h0080_0000);
    set_pair(1, 32'h3f80_0000, 32'h007f_ffff);
    set_pair(2, 32'hc000_0000, 32'hbf80_0000);
    set_pair(3, 32'hbf80_0000, 32'hc000_0000);
    run_once(1'b0, 1'b0);
    // NaNs, quiet then signaling compare.
    set_pair(0, 32'h7fc0_0000, 32'h3f80_0000);
    set_pair(1, 32'h3f80_0000, 32'h7f80_0001);
    set_pair(2, 32'hff80_0000, 32'hff80_0000);
    set_pair(3, 32'h0000_0000, 32'h0000_0001);
    run_once(1'b0, 1'b0);
    clear_sticky();
    set_pair(1, 32'h3f80_0000, 32'h4000_0000);
    run_once(1'b0, 1'b0);
    axi_read(addr_t'(`FPU_CMP_STATUS), rd);
    run_once(1'b1, 1'b0);
    clear_sticky();

    for (int n = 0; n < random_runs; n++) begin
      for (int i = 0; i < `FPU_CMP_LANES; i++) begin
        lane_a[i] = random_operand();
        lane_b[i] = (rand32() % 6 == 0) ? lane_a[i] : random_operand();
      end
      r = rand32();
      run_once(r[0], r[1] & r[2]);
      if (n % 50 == 49) clear_sticky();
    end

    repeat (2) @(posedge clk); // Let the checker see the last beat.
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts", check_count, err_count,
             timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpu_cmp_top.f ====
+incdir+hdl
hdl/fpu_cmp_pkg.sv
hdl/fpu_unpack.sv
hdl/fpu_compare.sv
hdl/fpu_cmp_collect.sv
hdl/fpu_cmp_regs.sv
hdl/fpu_cmp_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_fpu_cmp.sv

// ==== hdl/fpu_cmp_collect.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module fpu_cmp_collect (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       start_i,
  input  logic                                       lane_valid_i,
  input  fpu_cmp_pkg::cmp_flags_t [`FPU_CMP_LANES-1:0] lane_flags_i,
  input  logic                                       clear_sticky_i,
  output logic [4*`FPU_CMP_LANES-1:0]                result_o,
  output logic                                       done_o,
  output logic                                       sticky_o
);

  logic accept;
  logic any_invalid;

  assign accept = lane_valid_i && !start_i; // A restart drops the older run.

  always_comb begin
    any_invalid = 1'b0;
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      any_invalid = any_invalid | lane_flags_i[i].invalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      done_o   <= 1'b0;
      sticky_o <= 1'b0;
    end else begin
      if (start_i) begin
        done_o <= 1'b0;
      end else if (lane_valid_i) begin
        done_o <= 1'b1;
      end
      if (accept) begin
        result_o <= lane_flags_i; // Lane i in nibble i.
      end
      sticky_o <= (sticky_o && !clear_sticky_i) || (accept && any_invalid);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_cmp_config.svh ====
`ifndef FPU_CMP_CONFIG_SVH
`define FPU_CMP_CONFIG_SVH

// Parallel compare lanes.
`define FPU_CMP_LANES 4

// Signed unbiased exponent, one bit wider than the binary32 field.
`define FPU_CMP_EXP_W 9

// Stored fraction bits of binary32.
`define FPU_CMP_SIG_W 23

`define FPU_CMP_ADDR_W 6

// Operand words, one per lane.
`define FPU_CMP_A_BASE 'h00
`define FPU_CMP_B_BASE 'h10

`define FPU_CMP_CTRL   'h20
`define FPU_CMP_STATUS 'h24
`define FPU_CMP_RESULT 'h28

`endif

// ==== hdl/fpu_cmp_pkg.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

package fpu_cmp_pkg;

  typedef struct packed {
    logic                             sign;
    logic signed [`FPU_CMP_EXP_W-1:0] exponent;
    logic [`FPU_CMP_SIG_W-1:0]        fraction;
    logic                             is_zero;
    logic                             is_inf;
    logic                             is_nan;
  } fp_operand_t;

  typedef struct packed {
    fp_operand_t a;
    fp_operand_t b;
    logic        signaling;
  } fp_pair_t;

  // Field order matches one RESULT nibble.
  typedef struct packed {
    logic lt;
    logic eq;
    logic unordered;
    logic invalid;
  } cmp_flags_t;

  typedef struct packed {
    logic                            start;
    logic                            signaling;
    logic [`FPU_CMP_LANES-1:0][31:0] a_words;
    logic [`FPU_CMP_LANES-1:0][31:0] b_words;
  } cmp_req_t;

endpackage

`default_nettype wire

// ==== hdl/fpu_cmp_regs.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module fpu_cmp_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [`FPU_CMP_ADDR_W-1:0]  s_awaddr_i,
  input  logic                        s_awvalid_i,
  output logic                        s_awready_o,
  input  logic [31:0]                 s_wdata_i,
  input  logic [3:0]                  s_wstrb_i,
  input  logic                        s_wvalid_i,
  output logic                        s_wready_o,
  output logic [1:0]                  s_bresp_o,
  output logic                        s_bvalid_o,
  input  logic                        s_bready_i,
  input  logic [`FPU_CMP_ADDR_W-1:0]  s_araddr_i,
  input  logic                        s_arvalid_i,
  output logic                        s_arready_o,
  output logic [31:0]                 s_rdata_o,
  output logic [1:0]                  s_rresp_o,
  output logic                        s_rvalid_o,
  input  logic                        s_rready_i,
  output fpu_cmp_pkg::cmp_req_t       req_o,
  input  logic [4*`FPU_CMP_LANES-1:0] result_i,
  input  logic                        done_i,
  input  logic                        sticky_i,
  output logic                        clear_sticky_o
);

  typedef logic [`FPU_CMP_ADDR_W-1:0] addr_t;

  logic [`FPU_CMP_LANES-1:0][31:0] a_q;
  logic [`FPU_CMP_LANES-1:0][31:0] b_q;
  logic                            start_q;
  logic                            signaling_q;
  logic                            clear_q;
  logic                            bvalid_q;
  logic                            rvalid_q;
  logic [31:0]                     rdata_q;
  logic [31:0]                     rd_word;
  logic                            wr_en;
  logic                            rd_en;
  addr_t                           waddr;
  addr_t                           raddr;

  function automatic logic [31:0] merge_strb(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) begin
        res[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return res;
  endfunction

  assign waddr = {s_awaddr_i[`FPU_CMP_ADDR_W-1:2], 2'b00};
  assign raddr = {s_araddr_i[`FPU_CMP_ADDR_W-1:2], 2'b00};

  // AW and W are taken together, one write in flight.
  assign wr_en       = s_awvalid_i && s_wvalid_i && !bvalid_q;
  assign s_awready_o = wr_en;
  assign s_wready_o  = wr_en;
  assign rd_en       = s_arvalid_i && !rvalid_q;
  assign s_arready_o = !rvalid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q     <= 1'b0;
      signaling_q <= 1'b0;
      clear_q     <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
      if (wr_en) begin
        bvalid_q <= 1'b1;
        if (waddr == addr_t'(`FPU_CMP_CTRL) && s_wstrb_i[0]) begin
          start_q     <= s_wdata_i[0];
          signaling_q <= s_wdata_i[1];
        end
        if (waddr == addr_t'(`FPU_CMP_STATUS) && s_wstrb_i[0]) begin
          clear_q <= s_wdata_i[1]; // Write one to clear.
        end
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < `FPU_CMP_LANES; i++) begin
        if (waddr == addr_t'(`FPU_CMP_A_BASE + 4 * i)) begin
          a_q[i] <= merge_strb(a_q[i], s_wdata_i, s_wstrb_i);
        end
        if (waddr == addr_t'(`FPU_CMP_B_BASE + 4 * i)) begin
          b_q[i] <= merge_strb(b_q[i], s_wdata_i, s_wstrb_i);
        end
      end
    end
  end

  always_comb begin
    rd_word = '0; // Unmapped reads return zero.
    for (int i = 0; i < `FPU_CMP_LANES; i++) begin
      if (raddr == addr_t'(`FPU_CMP_A_BASE + 4 * i)) begin
        rd_word = a_q[i];
      end
      if (raddr == addr_t'(`FPU_CMP_B_BASE + 4 * i)) begin
        rd_word = b_q[i];
      end
    end
    case (raddr)
      addr_t'(`FPU_CMP_CTRL):   rd_word = {30'b0, signaling_q, 1'b0};
      addr_t'(`FPU_CMP_STATUS): rd_word = {30'b0, sticky_i, done_i};
      addr_t'(`FPU_CMP_RESULT): rd_word[4*`FPU_CMP_LANES-1:0] = result_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  assign s_bvalid_o     = bvalid_q;
  assign s_bresp_o      = 2'b00; // OKAY.
  assign s_rvalid_o     = rvalid_q;
  assign s_rdata_o      = rdata_q;
  assign s_rresp_o      = 2'b00;
  assign clear_sticky_o = clear_q;

  always_comb begin
    req_o.start     = start_q;
    req_o.signaling = signaling_q;
    req_o.a_words   = a_q;
    req_o.b_words   = b_q;
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_cmp_top.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module fpu_cmp_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`FPU_CMP_ADDR_W-1:0] s_awaddr_i,
  input  logic                       s_awvalid_i,
  output logic                       s_awready_o,
  input  logic [31:0]                s_wdata_i,
  input  logic [3:0]                 s_wstrb_i,
  input  logic                       s_wvalid_i,
  output logic                       s_wready_o,
  output logic [1:0]                 s_bresp_o,
  output logic                       s_bvalid_o,
  input  logic                       s_bready_i,
  input  logic [`FPU_CMP_ADDR_W-1:0] s_araddr_i,
  input  logic                       s_arvalid_i,
  output logic                       s_arready_o,
  output logic [31:0]                s_rdata_o,
  output logic [1:0]                 s_rresp_o,
  output logic                       s_rvalid_o,
  input  logic                       s_rready_i
);

  import fpu_cmp_pkg::*;

  cmp_req_t                          req;
  fp_pair_t [`FPU_CMP_LANES-1:0]     pairs;
  logic                              unpack_valid;
  cmp_flags_t [`FPU_CMP_LANES-1:0]   lane_flags;
  logic [`FPU_CMP_LANES-1:0]         lane_valid;
  logic [4*`FPU_CMP_LANES-1:0]       result;
  logic                              done;
  logic                              sticky;
  logic                              clear_sticky;

  fpu_cmp_regs u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .s_awaddr_i     (s_awaddr_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wstrb_i      (s_wstrb_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .s_bresp_o      (s_bresp_o),
    .s_bvalid_o     (s_bvalid_o),
    .s_bready_i     (s_bready_i),
    .s_araddr_i     (s_araddr_i),
    .s_arvalid_i    (s_arvalid_i),
    .s_arready_o    (s_arready_o),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .s_rvalid_o     (s_rvalid_o),
    .s_rready_i     (s_rready_i),
    .req_o          (req),
    .result_i       (result),
    .done_i         (done),
    .sticky_i       (sticky),
    .clear_sticky_o (clear_sticky)
  );

  fpu_unpack u_unpack (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req),
    .pairs_o (pairs),
    .valid_o (unpack_valid)
  );

  for (genvar i = 0; i < `FPU_CMP_LANES; i++) begin : g_lane
    cmp_flags_t flags_d;
    cmp_flags_t flags_q;
    logic       valid_q;

    fpu_compare u_compare (
      .a_i         (pairs[i].a),
      .b_i         (pairs[i].b),
      .signaling_i (pairs[i].signaling),
      .flags_o     (flags_d)
    );

    always_ff @(posedge clk_i) begin
      flags_q <= flags_d;
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= unpack_valid && !req.start; // Killed by a restart.
      end
    end

    assign lane_flags[i] = flags_q;
    assign lane_valid[i] = valid_q;
  end

  fpu_cmp_collect u_collect (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .start_i        (req.start),
    .lane_valid_i   (&lane_valid),
    .lane_flags_i   (lane_flags),
    .clear_sticky_i (clear_sticky),
    .result_o       (result),
    .done_o         (done),
    .sticky_o       (sticky)
  );

endmodule

`default_nettype wire

// ==== hdl/fpu_compare.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module fpu_compare (
  input  fpu_cmp_pkg::fp_operand_t a_i,
  input  fpu_cmp_pkg::fp_operand_t b_i,
  input  logic                     signaling_i,
  output fpu_cmp_pkg::cmp_flags_t  flags_o
);

  logic a_snan;
  logic b_snan;
  logic exp_eq;
  logic exp_lt;
  logic frac_eq;
  logic frac_lt;
  logic mag_eq;
  logic mag_lt;
  logic unordered;
  logic ordered_eq;
  logic ordered_lt;

  // Quiet bit clear means signaling.
  assign a_snan = a_i.is_nan && !a_i.fraction[`FPU_CMP_SIG_W-1];
  assign b_snan = b_i.is_nan && !b_i.fraction[`FPU_CMP_SIG_W-1];

  assign exp_eq  = a_i.exponent == b_i.exponent;
  assign exp_lt  = $signed(a_i.exponent) < $signed(b_i.exponent);
  assign frac_eq = a_i.fraction == b_i.fraction;
  assign frac_lt = a_i.fraction < b_i.fraction;
  assign mag_eq  = exp_eq && frac_eq;
  assign mag_lt  = exp_lt || (exp_eq && frac_lt);

  assign unordered = a_i.is_nan || b_i.is_nan;

  always_comb begin
    ordered_eq = 1'b0;
    ordered_lt = 1'b0;
    if (a_i.is_zero && b_i.is_zero) begin
      ordered_eq = 1'b1; // Signs ignored.
    end else if (a_i.is_zero) begin
      ordered_lt = !b_i.sign;
    end else if (b_i.is_zero) begin
      ordered_lt = a_i.sign;
    end else if (a_i.sign != b_i.sign) begin
      ordered_lt = a_i.sign;
    end else if (a_i.is_inf && b_i.is_inf) begin
      ordered_eq = 1'b1;
    end else if (a_i.is_inf) begin
      ordered_lt = a_i.sign;
    end else if (b_i.is_inf) begin
      ordered_lt = !b_i.sign;
    end else if (mag_eq) begin
      ordered_eq = 1'b1;
    end else begin
      ordered_lt = mag_lt ^ a_i.sign; // Negatives order in reverse.
    end
  end

  always_comb begin
    flags_o.lt        = !unordered && ordered_lt;
    flags_o.eq        = !unordered && ordered_eq;
    flags_o.unordered = unordered;
    flags_o.invalid   = a_snan || b_snan || (signaling_i && unordered);
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_unpack.sv ====
`default_nettype none
`include "fpu_cmp_config.svh"

module fpu_unpack (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  fpu_cmp_pkg::cmp_req_t                     req_i,
  output fpu_cmp_pkg::fp_pair_t [`FPU_CMP_LANES-1:0] pairs_o,
  output logic                                      valid_o
);

  import fpu_cmp_pkg::*;

  localparam int unsigned sig_w = `FPU_CMP_SIG_W;
  localparam int unsigned exp_w = `FPU_CMP_EXP_W;
  localparam int unsigned bias  = 127;

  function automatic fp_operand_t decode(input logic [31:0] word);
    fp_operand_t op;
    logic [7:0]  field;
    logic        frac_zero;
    field     = word[30:sig_w];
    frac_zero = word[sig_w-1:0] == '0;
    op.sign     = word[31];
    op.fraction = word[sig_w-1:0]; // No hidden bit.
    // Field 0 lands on -127, below every normal exponent.
    op.exponent = exp_w'({1'b0, field}) - exp_w'(bias);
    op.is_zero  = (field == 8'h00) && frac_zero;
    op.is_inf   = (field == 8'hff) && frac_zero;
    op.is_nan   = (field == 8'hff) && !frac_zero;
    return op;
  endfunction

  always_ff @(posedge clk_i) begin
    if (req_i.start) begin
      for (int i = 0; i < `FPU_CMP_LANES; i++) begin
        pairs_o[i].a         <= decode(req_i.a_words[i]);
        pairs_o[i].b         <= decode(req_i.b_words[i]);
        pairs_o[i].signaling <= req_i.signaling;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i.start; // One cycle after start.
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the FPU compare testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
  --top-module tb_fpu_cmp \
  -f fpu_cmp_top.f \
  --Mdir "$OBJ" -o tb_fpu_cmp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_fpu_cmp" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
